/* ex_core_slice.f */
source/ex_pkg.sv
source/wb_bus_if.sv
source/ex_forwarding.sv
source/ex_alu.sv
source/ex_retire_stage.sv
source/ex_core_slice.sv
verif/tb_ex_core_slice.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the execute slice testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary -j 0 -f ex_core_slice.f --top-module tb_ex_core_slice -o tb_ex_core_slice

# A failing run still reaches the search below
output=$(./obj_dir/tb_ex_core_slice 2>&1) || true
echo "$output"

if echo "$output" | grep -q "^TEST PASS$"; then
	exit 0
else
	exit 1
fi

/* verif/tb_ex_core_slice.sv */
`timescale 1ns/1ps

module tb_ex_core_slice;

	// One issued instruction plus idle cycles after it
	typedef struct {
		string name;
		ex_pkg::ex_op_t op;
		ex_pkg::reg_ptr_t a_ptr;
		logic a_sys;
		logic a_imm;
		ex_pkg::reg_ptr_t b_ptr;
		logic b_sys;
		logic b_imm;
		ex_pkg::word_t imm;
		ex_pkg::reg_ptr_t dest;
		logic dest_sys;
		int gap;
	} row_t;

	// DUT inputs
	logic clock;
	logic rst_n;
	logic issue_valid;
	ex_pkg::ex_op_t op;
	ex_pkg::reg_ptr_t src_a_pointer;
	logic src_a_sysreg;
	logic src_a_imm;
	ex_pkg::reg_ptr_t src_b_pointer;
	logic src_b_sysreg;
	logic src_b_imm;
	ex_pkg::word_t imm_data;
	ex_pkg::reg_ptr_t dest_pointer;
	logic dest_sysreg;
	// DUT outputs
	logic result_valid;
	ex_pkg::word_t result_data;
	ex_pkg::reg_ptr_t result_dest;
	logic result_dest_sysreg;
	ex_pkg::word_t spr_value;

	// Stimulus table
	row_t rows[$];
	row_t idle_row;

	// Sequential reference state
	ex_pkg::word_t ref_gr [ex_pkg::gr_count];
	ex_pkg::word_t ref_spr;
	// Expected result of the instruction now being sampled
	logic pend_valid;
	ex_pkg::word_t pend_data;
	ex_pkg::reg_ptr_t pend_dest;
	logic pend_dest_sys;
	string pend_name;
	// Reference SPR delayed to the commit point
	ex_pkg::word_t spr_q0;
	ex_pkg::word_t spr_q1;

	// Run length guard
	int cycle_count = 0;
	int cycle_limit = 0;

	ex_core_slice UUT (
		.clock(clock),
		.rst_n(rst_n),
		.issue_valid(issue_valid),
		.op(op),
		.src_a_pointer(src_a_pointer),
		.src_a_sysreg(src_a_sysreg),
		.src_a_imm(src_a_imm),
		.src_b_pointer(src_b_pointer),
		.src_b_sysreg(src_b_sysreg),
		.src_b_imm(src_b_imm),
		.imm_data(imm_data),
		.dest_pointer(dest_pointer),
		.dest_sysreg(dest_sysreg),
		.result_valid(result_valid),
		.result_data(result_data),
		.result_dest(result_dest),
		.result_dest_sysreg(result_dest_sysreg),
		.spr_value(spr_value)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("TEST FAIL");
			$fatal(1, "Timeout: the run did not finish within %0d cycles", cycle_limit);
		end
	end

	task automatic check_value(input string test_name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Fail %s expected %h actual %h", test_name, expected, actual);
			$display("TEST FAIL");
			$fatal(1, "Value mismatch in %s", test_name);
		end
	endtask

	task automatic add_row(input string name, input ex_pkg::ex_op_t row_op, input int a_ptr,
		input int a_sys, input int a_imm, input int b_ptr, input int b_sys, input int b_imm,
		input ex_pkg::word_t imm, input int dest, input int dest_sys, input int gap);
		row_t r;
		r.name = name;
		r.op = row_op;
		r.a_ptr = ex_pkg::reg_ptr_t'(a_ptr);
		r.a_sys = (a_sys != 0);
		r.a_imm = (a_imm != 0);
		r.b_ptr = ex_pkg::reg_ptr_t'(b_ptr);
		r.b_sys = (b_sys != 0);
		r.b_imm = (b_imm != 0);
		r.imm = imm;
		r.dest = ex_pkg::reg_ptr_t'(dest);
		r.dest_sys = (dest_sys != 0);
		r.gap = gap;
		rows.push_back(r);
	endtask

	// Architectural view of one source operand
	function automatic ex_pkg::word_t read_operand(input ex_pkg::reg_ptr_t ptr, input logic sys,
		input logic imm, input ex_pkg::word_t imm_value);
		if (imm)
			return imm_value;
		if (!sys)
			return ref_gr[ptr];
		if (ptr == ex_pkg::sysreg_spr)
			return ref_spr;
		// Unimplemented system registers
		return '0;
	endfunction

	// Strictly sequential execution of one row
	task automatic execute_reference(input row_t r);
		ex_pkg::word_t a;
		ex_pkg::word_t b;
		ex_pkg::word_t res;
		a = read_operand(r.a_ptr, r.a_sys, r.a_imm, r.imm);
		b = read_operand(r.b_ptr, r.b_sys, r.b_imm, r.imm);
		case (r.op)
			ex_pkg::op_add: res = a + b;
			ex_pkg::op_sub: res = a - b;
			ex_pkg::op_and: res = a & b;
			ex_pkg::op_or: res = a | b;
			ex_pkg::op_xor: res = a ^ b;
			ex_pkg::op_shl: res = a << b[4:0];
			ex_pkg::op_shr: res = a >> b[4:0];
			ex_pkg::op_mov: res = b;
			ex_pkg::op_spadd: res = a;
			default: res = '0;
		endcase
		// SP adjust beats a sysreg destination
		if (r.op == ex_pkg::op_spadd)
			ref_spr = a + b;
		else if (r.dest_sys && r.dest == ex_pkg::sysreg_spr)
			ref_spr = res;
		if (!r.dest_sys || r.op == ex_pkg::op_spadd)
			ref_gr[r.dest] = res;
		pend_valid = 1'b1;
		pend_data = res;
		pend_dest = r.dest;
		pend_dest_sys = r.dest_sys && r.op != ex_pkg::op_spadd;
		pend_name = r.name;
	endtask

	// One clock: drive a row or idle, then check what the DUT sampled at this edge
	task automatic apply_cycle(input logic valid, input row_t r);
		logic exp_valid;
		ex_pkg::word_t exp_data;
		ex_pkg::reg_ptr_t exp_dest;
		logic exp_dest_sys;
		string exp_name;
		ex_pkg::word_t exp_spr;
		@(posedge clock);
		exp_valid = pend_valid;
		exp_data = pend_data;
		exp_dest = pend_dest;
		exp_dest_sys = pend_dest_sys;
		exp_name = pend_name;
		// SPR commits two edges after the sampling edge
		exp_spr = spr_q1;
		spr_q1 = spr_q0;
		spr_q0 = ref_spr;
		if (valid) begin
			execute_reference(r);
		end
		else begin
			pend_valid = 1'b0;
			pend_name = "idle";
		end
		issue_valid <= valid;
		op <= r.op;
		src_a_pointer <= r.a_ptr;
		src_a_sysreg <= r.a_sys;
		src_a_imm <= r.a_imm;
		src_b_pointer <= r.b_ptr;
		src_b_sysreg <= r.b_sys;
		src_b_imm <= r.b_imm;
		imm_data <= r.imm;
		dest_pointer <= r.dest;
		dest_sysreg <= r.dest_sys;
		@(negedge clock);
		check_value({exp_name, " valid"}, 32'(exp_valid), 32'(result_valid));
		if (exp_valid) begin
			check_value({exp_name, " data"}, exp_data, result_data);
			check_value({exp_name, " dest"}, 32'(exp_dest), 32'(result_dest));
			check_value({exp_name, " dest sysreg"}, 32'(exp_dest_sys), 32'(result_dest_sysreg));
		end
		check_value({exp_name, " spr"}, exp_spr, spr_value);
	endtask

	task automatic build_table();
		int a_sys;
		int b_sys;
		int d_sys;
		ex_pkg::ex_op_t rand_op;
		// Name, op, A ptr/sys/imm, B ptr/sys/imm, immediate, dest ptr/sys, gap
		add_row("mov imm r1", ex_pkg::op_mov, 0, 0, 0, 0, 0, 1, 32'h1234_5678, 1, 0, 3);
		add_row("mov imm r2", ex_pkg::op_mov, 0, 0, 0, 0, 0, 1, 32'h0000_0009, 2, 0, 3);
		add_row("add reg", ex_pkg::op_add, 1, 0, 0, 2, 0, 0, 0, 3, 0, 3);
		add_row("sub imm", ex_pkg::op_sub, 1, 0, 0, 0, 0, 1, 32'h0000_1000, 4, 0, 3);
		add_row("and reg", ex_pkg::op_and, 1, 0, 0, 3, 0, 0, 0, 5, 0, 3);
		add_row("or imm", ex_pkg::op_or, 2, 0, 0, 0, 0, 1, 32'hF0F0_0000, 6, 0, 3);
		add_row("xor reg", ex_pkg::op_xor, 1, 0, 0, 4, 0, 0, 0, 7, 0, 3);
		add_row("shl reg", ex_pkg::op_shl, 1, 0, 0, 2, 0, 0, 0, 8, 0, 3);
		add_row("shr imm", ex_pkg::op_shr, 1, 0, 0, 0, 0, 1, 32'h0000_0024, 9, 0, 3);
		add_row("spadd spr", ex_pkg::op_spadd, 1, 1, 0, 0, 0, 1, 32'hFFFF_FFF0, 10, 0, 3);
		add_row("mov spr read", ex_pkg::op_mov, 0, 0, 0, 1, 1, 0, 0, 11, 0, 3);
		// Back-to-back dependencies
		add_row("fwd seed", ex_pkg::op_add, 1, 0, 0, 0, 0, 1, 1, 12, 0, 0);
		add_row("fwd wb a", ex_pkg::op_add, 12, 0, 0, 0, 0, 1, 2, 13, 0, 0);
		add_row("fwd wb b", ex_pkg::op_sub, 2, 0, 0, 13, 0, 0, 0, 14, 0, 0);
		add_row("fwd wb both", ex_pkg::op_add, 14, 0, 0, 14, 0, 0, 0, 15, 0, 1);
		add_row("fwd prev a", ex_pkg::op_xor, 15, 0, 0, 0, 0, 1, 32'h00FF_00FF, 16, 0, 1);
		add_row("fwd prev b", ex_pkg::op_and, 1, 0, 0, 16, 0, 0, 0, 17, 0, 1);
		add_row("fwd prev both", ex_pkg::op_add, 17, 0, 0, 17, 0, 0, 0, 18, 0, 0);
		add_row("fwd mov r19", ex_pkg::op_mov, 0, 0, 0, 0, 0, 1, 7, 19, 0, 0);
		add_row("fwd mov r20", ex_pkg::op_mov, 0, 0, 0, 0, 0, 1, 9, 20, 0, 0);
		add_row("fwd prev a wb b", ex_pkg::op_sub, 19, 0, 0, 20, 0, 0, 0, 21, 0, 0);
		// Same register in both slots
		add_row("dup old", ex_pkg::op_mov, 0, 0, 0, 0, 0, 1, 32'h0000_AAAA, 22, 0, 0);
		add_row("dup new", ex_pkg::op_mov, 0, 0, 0, 0, 0, 1, 32'h0000_5555, 22, 0, 0);
		add_row("dup read", ex_pkg::op_add, 22, 0, 0, 0, 0, 1, 0, 23, 0, 3);
		// SPR forwarding
		add_row("spadd then read", ex_pkg::op_spadd, 1, 1, 0, 0, 0, 1, 32'h20, 24, 0, 0);
		add_row("read spr wb", ex_pkg::op_mov, 0, 0, 0, 1, 1, 0, 0, 25, 0, 0);
		add_row("mov to spr", ex_pkg::op_mov, 0, 0, 0, 0, 0, 1, 32'h2000, 1, 1, 0);
		add_row("spadd after mov", ex_pkg::op_spadd, 1, 1, 0, 0, 0, 1, 8, 26, 0, 1);
		add_row("spadd prev", ex_pkg::op_spadd, 1, 1, 0, 0, 0, 1, 4, 27, 0, 1);
		add_row("read spr prev", ex_pkg::op_mov, 0, 0, 0, 1, 1, 0, 0, 28, 0, 3);
		// Immediates and other system registers
		add_row("imm seed", ex_pkg::op_mov, 0, 0, 0, 0, 0, 1, 32'h11, 29, 0, 0);
		add_row("imm no fwd", ex_pkg::op_add, 29, 0, 1, 29, 0, 1, 32'h100, 30, 0, 0);
		add_row("sysreg write other", ex_pkg::op_mov, 0, 0, 0, 0, 0, 1, 32'h99, 7, 1, 0);
		add_row("sysreg read other", ex_pkg::op_mov, 0, 0, 0, 7, 1, 0, 0, 31, 0, 0);
		add_row("sysreg read zero", ex_pkg::op_or, 5, 1, 0, 0, 0, 1, 32'h3, 31, 0, 3);
		// Random mix, small pointer range for more hazards
		for (int i = 0; i < 200; i++) begin
			rand_op = ex_pkg::ex_op_t'(4'($urandom_range(8, 0)));
			a_sys = ($urandom_range(7, 0) == 0) ? 1 : 0;
			b_sys = ($urandom_range(7, 0) == 0) ? 1 : 0;
			d_sys = ($urandom_range(7, 0) == 0) ? 1 : 0;
			add_row($sformatf("random %0d", i), rand_op,
				a_sys ? $urandom_range(3, 0) : $urandom_range(15, 0), a_sys,
				(($urandom_range(3, 0) == 0) ? 1 : 0),
				b_sys ? $urandom_range(3, 0) : $urandom_range(15, 0), b_sys,
				(($urandom_range(3, 0) == 0) ? 1 : 0), $urandom(),
				d_sys ? $urandom_range(3, 0) : $urandom_range(15, 0), d_sys,
				($urandom_range(3, 0) == 3) ? $urandom_range(2, 1) : 0);
		end
		// Let everything commit before the sweep
		rows[rows.size()-1].gap = 3;
		for (int i = 0; i < ex_pkg::gr_count; i++) begin
			add_row($sformatf("sweep r%0d", i), ex_pkg::op_mov, 0, 0, 0, i, 0, 0, 0, i, 0, 0);
		end
		add_row("sweep spr", ex_pkg::op_mov, 0, 0, 0, 1, 1, 0, 0, 5, 1, 0);
	endtask

	initial begin
		rst_n = 1'b0;
		issue_valid = 1'b0;
		op = ex_pkg::op_add;
		src_a_pointer = '0;
		src_a_sysreg = 1'b0;
		src_a_imm = 1'b0;
		src_b_pointer = '0;
		src_b_sysreg = 1'b0;
		src_b_imm = 1'b0;
		imm_data = '0;
		dest_pointer = '0;
		dest_sysreg = 1'b0;
		for (int i = 0; i < ex_pkg::gr_count; i++) begin
			ref_gr[i] = '0;
		end
		ref_spr = ex_pkg::spr_reset_value;
		spr_q0 = ex_pkg::spr_reset_value;
		spr_q1 = ex_pkg::spr_reset_value;
		pend_valid = 1'b0;
		pend_name = "reset idle";
		void'($urandom(32'h0c451da4));
		build_table();
		idle_row = rows[0];
		cycle_limit = rows.size() + 20;
		foreach (rows[i]) begin
			cycle_limit += rows[i].gap;
		end
		repeat (5) @(posedge clock);
		rst_n <= 1'b1;
		// Quiet cycles after reset
		repeat (3) apply_cycle(1'b0, idle_row);
		foreach (rows[i]) begin
			apply_cycle(1'b1, rows[i]);
			repeat (rows[i].gap) apply_cycle(1'b0, idle_row);
		end
		// Drain the last result and SPR commit
		repeat (3) apply_cycle(1'b0, idle_row);
		$display("TEST PASS");
		$finish;
	end

endmodule

/* source/ex_core_slice.sv */
`timescale 1ns/1ps

module ex_core_slice (
	input logic clock,
	input logic rst_n,
	// Issued instruction
	input logic issue_valid,
	input ex_pkg::ex_op_t op,
	input ex_pkg::reg_ptr_t src_a_pointer,
	input logic src_a_sysreg,
	input logic src_a_imm,
	input ex_pkg::reg_ptr_t src_b_pointer,
	input logic src_b_sysreg,
	input logic src_b_imm,
	input ex_pkg::word_t imm_data,
	input ex_pkg::reg_ptr_t dest_pointer,
	input logic dest_sysreg,
	// Result one cycle after issue
	output logic result_valid,
	output ex_pkg::word_t result_data,
	output ex_pkg::reg_ptr_t result_dest,
	output logic result_dest_sysreg,
	// Committed stack pointer
	output ex_pkg::word_t spr_value
);

	// Writeback slots
	wb_bus_if wb ();
	wb_bus_if prev_wb ();

	// Register file reads before forwarding
	ex_pkg::word_t read_a_data;
	ex_pkg::word_t read_b_data;
	// Forwarded operands
	ex_pkg::word_t operand_a;
	ex_pkg::word_t operand_b;
	// ALU outputs
	ex_pkg::word_t alu_result;
	logic spr_write;
	ex_pkg::word_t spr_next;
	// SP adjust always retires to a general register
	logic retire_dest_sysreg;

	assign retire_dest_sysreg = dest_sysreg && op != ex_pkg::op_spadd;

	ex_retire_stage u_retire (
		.clock(clock),
		.rst_n(rst_n),
		.issue_valid(issue_valid),
		.result(alu_result),
		.dest_pointer(dest_pointer),
		.dest_sysreg(retire_dest_sysreg),
		.spr_write(spr_write),
		.spr_next(spr_next),
		.read_a_pointer(src_a_pointer),
		.read_a_sysreg(src_a_sysreg),
		.read_b_pointer(src_b_pointer),
		.read_b_sysreg(src_b_sysreg),
		.read_a_data(read_a_data),
		.read_b_data(read_b_data),
		.spr_value(spr_value),
		.wb(wb.source),
		.prev_wb(prev_wb.source)
	);

	// Operand A
	ex_forwarding forward_a (
		.src_pointer(src_a_pointer),
		.src_sysreg(src_a_sysreg),
		.src_imm(src_a_imm),
		.imm_data(imm_data),
		.reg_data(read_a_data),
		.wb(wb.sink),
		.prev_wb(prev_wb.sink),
		.operand(operand_a)
	);

	// Operand B shares the immediate
	ex_forwarding forward_b (
		.src_pointer(src_b_pointer),
		.src_sysreg(src_b_sysreg),
		.src_imm(src_b_imm),
		.imm_data(imm_data),
		.reg_data(read_b_data),
		.wb(wb.sink),
		.prev_wb(prev_wb.sink),
		.operand(operand_b)
	);

	ex_alu u_alu (
		.op(op),
		.operand_a(operand_a),
		.operand_b(operand_b),
		.dest_pointer(dest_pointer),
		.dest_sysreg(dest_sysreg),
		.result(alu_result),
		.spr_write(spr_write),
		.spr_next(spr_next)
	);

	// Newer slot is the visible result
	assign result_valid = wb.gr_valid;
	assign result_data = wb.gr_data;
	assign result_dest = wb.gr_dest;
	assign result_dest_sysreg = wb.gr_dest_sysreg;

endmodule

/* source/ex_retire_stage.sv */
`timescale 1ns/1ps

module ex_retire_stage (
	input logic clock,
	input logic rst_n,
	input logic issue_valid,
	input ex_pkg::word_t result,
	input ex_pkg::reg_ptr_t dest_pointer,
	input logic dest_sysreg,
	input logic spr_write,
	input ex_pkg::word_t spr_next,
	input ex_pkg::reg_ptr_t read_a_pointer,
	input logic read_a_sysreg,
	input ex_pkg::reg_ptr_t read_b_pointer,
	input logic read_b_sysreg,
	output ex_pkg::word_t read_a_data,
	output ex_pkg::word_t read_b_data,
	output ex_pkg::word_t spr_value,
	wb_bus_if.source wb,
	wb_bus_if.source prev_wb
);

	// Architectural state
	ex_pkg::word_t gr_file [ex_pkg::gr_count];
	ex_pkg::word_t spr;

	// Committed register contents for one read port
	function automatic ex_pkg::word_t read_port(
		input ex_pkg::reg_ptr_t ptr,
		input logic sysreg,
		input ex_pkg::word_t gr_value,
		input ex_pkg::word_t spr_current
	);
		ex_pkg::word_t data;
		if (!sysreg) begin
			data = gr_value;
		end
		else if (ptr == ex_pkg::sysreg_spr) begin
			data = spr_current;
		end
		else begin
			// Other system registers do not exist here
			data = '0;
		end
		return data;
	endfunction

	// Slot valid flags
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			wb.gr_valid <= 1'b0;
			wb.spr_valid <= 1'b0;
			prev_wb.gr_valid <= 1'b0;
			prev_wb.spr_valid <= 1'b0;
		end
		else begin
			// New slot from the issue cycle
			wb.gr_valid <= issue_valid;
			wb.spr_valid <= issue_valid && spr_write;
			// Age into the older slot
			prev_wb.gr_valid <= wb.gr_valid;
			prev_wb.spr_valid <= wb.spr_valid;
		end
	end

	// Slot payload
	always_ff @(posedge clock) begin
		if (issue_valid) begin
			wb.gr_data <= result;
			wb.gr_dest <= dest_pointer;
			wb.gr_dest_sysreg <= dest_sysreg;
			wb.spr_data <= spr_next;
		end
		prev_wb.gr_data <= wb.gr_data;
		prev_wb.gr_dest <= wb.gr_dest;
		prev_wb.gr_dest_sysreg <= wb.gr_dest_sysreg;
		prev_wb.spr_data <= wb.spr_data;
	end

	// Commit of the older slot
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < ex_pkg::gr_count; i++) begin
				gr_file[i] <= '0;
			end
			spr <= ex_pkg::spr_reset_value;
		end
		else begin
			// General destination
			if (prev_wb.gr_valid && !prev_wb.gr_dest_sysreg) begin
				gr_file[prev_wb.gr_dest] <= prev_wb.gr_data;
			end
			// Stack pointer update
			if (prev_wb.spr_valid) begin
				spr <= prev_wb.spr_data;
			end
		end
	end

	// Read ports
	assign read_a_data = read_port(read_a_pointer, read_a_sysreg,
		gr_file[read_a_pointer], spr);
	assign read_b_data = read_port(read_b_pointer, read_b_sysreg,
		gr_file[read_b_pointer], spr);

	assign spr_value = spr;

endmodule

/* source/ex_alu.sv */
`timescale 1ns/1ps

module ex_alu (
	input ex_pkg::ex_op_t op,
	input ex_pkg::word_t operand_a,
	input ex_pkg::word_t operand_b,
	input ex_pkg::reg_ptr_t dest_pointer,
	input logic dest_sysreg,
	output ex_pkg::word_t result,
	output logic spr_write,
	output ex_pkg::word_t spr_next
);

	// Shared adder
	ex_pkg::word_t sum;
	// Shift distance from operand B
	logic [ex_pkg::shamt_width-1:0] shamt;
	// Destination is the stack pointer
	logic dest_is_spr;
	// Stack pointer adjust
	logic is_spadd;

	assign sum = operand_a + operand_b;
	assign shamt = operand_b[ex_pkg::shamt_width-1:0];
	assign dest_is_spr = dest_sysreg && dest_pointer == ex_pkg::sysreg_spr;
	assign is_spadd = op == ex_pkg::op_spadd;

	// Result select
	always_comb begin
		case (op)
			ex_pkg::op_add: begin
				result = sum;
			end
			ex_pkg::op_sub: begin
				result = operand_a - operand_b;
			end
			ex_pkg::op_and: begin
				result = operand_a & operand_b;
			end
			ex_pkg::op_or: begin
				result = operand_a | operand_b;
			end
			ex_pkg::op_xor: begin
				result = operand_a ^ operand_b;
			end
			// Logical shifts only
			ex_pkg::op_shl: begin
				result = operand_a << shamt;
			end
			ex_pkg::op_shr: begin
				result = operand_a >> shamt;
			end
			ex_pkg::op_mov: begin
				result = operand_b;
			end
			// Old stack pointer goes to the destination
			ex_pkg::op_spadd: begin
				result = operand_a;
			end
			default: begin
				result = '0;
			end
		endcase
	end

	// SPR update
	always_comb begin
		spr_write = 1'b0;
		spr_next = result;
		if (is_spadd) begin
			// Adjust wins over any sysreg destination
			spr_write = 1'b1;
			spr_next = sum;
		end
		else if (dest_is_spr) begin
			spr_write = 1'b1;
		end
	end

endmodule

/* source/ex_forwarding.sv */
`timescale 1ns/1ps

module ex_forwarding (
	input ex_pkg::reg_ptr_t src_pointer,
	input logic src_sysreg,
	input logic src_imm,
	input ex_pkg::word_t imm_data,
	input ex_pkg::word_t reg_data,
	wb_bus_if.sink wb,
	wb_bus_if.sink prev_wb,
	output ex_pkg::word_t operand
);

	// One forwarding step against a single writeback slot
	function automatic ex_pkg::word_t rewrite(
		input ex_pkg::reg_ptr_t ptr,
		input logic sysreg,
		input ex_pkg::word_t data_in,
		input logic slot_valid,
		input ex_pkg::word_t slot_gr_data,
		input ex_pkg::reg_ptr_t slot_dest,
		input logic slot_dest_sysreg,
		input logic slot_spr_valid,
		input ex_pkg::word_t slot_spr_data
	);
		ex_pkg::word_t data_out;
		data_out = data_in;
		if (slot_valid) begin
			// Stack pointer read hits a pending SPR update
			if (sysreg && ptr == ex_pkg::sysreg_spr && slot_spr_valid) begin
				data_out = slot_spr_data;
			end
			// General read hits a pending general write
			else if (!sysreg && !slot_dest_sysreg && ptr == slot_dest) begin
				data_out = slot_gr_data;
			end
		end
		return data_out;
	endfunction

	// Older slot first
	ex_pkg::word_t prev_data;
	// Then the newer slot on top
	ex_pkg::word_t curr_data;

	assign prev_data = rewrite(src_pointer, src_sysreg, reg_data,
		prev_wb.gr_valid, prev_wb.gr_data, prev_wb.gr_dest,
		prev_wb.gr_dest_sysreg, prev_wb.spr_valid, prev_wb.spr_data);

	assign curr_data = rewrite(src_pointer, src_sysreg, prev_data,
		wb.gr_valid, wb.gr_data, wb.gr_dest,
		wb.gr_dest_sysreg, wb.spr_valid, wb.spr_data);

	// Immediates bypass forwarding entirely
	assign operand = src_imm ? imm_data : curr_data;

endmodule

/* source/wb_bus_if.sv */
`timescale 1ns/1ps

interface wb_bus_if;

	// Slot holds a live instruction
	logic gr_valid;
	// Result to be retired
	ex_pkg::word_t gr_data;
	// Destination register
	ex_pkg::reg_ptr_t gr_dest;
	// Destination names a system register
	logic gr_dest_sysreg;
	// Instruction updates the stack pointer
	logic spr_valid;
	// New stack pointer value
	ex_pkg::word_t spr_data;

	// Retire stage side
	modport source (
		output gr_valid, gr_data, gr_dest, gr_dest_sysreg, spr_valid, spr_data
	);

	// Forwarding and result side
	modport sink (
		input gr_valid, gr_data, gr_dest, gr_dest_sysreg, spr_valid, spr_data
	);

endinterface

/* source/ex_pkg.sv */
package ex_pkg;

	// Datapath and pointer widths
	localparam int word_width = 32;
	localparam int ptr_width = 5;

	// Shift amount taken from the low bits of operand B
	localparam int shamt_width = 5;

	// Register contents, immediates and results
	typedef logic [word_width-1:0] word_t;

	// Names a general register or a system register
	typedef logic [ptr_width-1:0] reg_ptr_t;

	// ALU operations
	typedef enum logic [3:0] {
		op_add = 4'd0,
		op_sub = 4'd1,
		op_and = 4'd2,
		op_or = 4'd3,
		op_xor = 4'd4,
		op_shl = 4'd5,
		op_shr = 4'd6,
		op_mov = 4'd7,
		op_spadd = 4'd8
	} ex_op_t;

	// Stack pointer system register
	localparam reg_ptr_t sysreg_spr = 5'd1;

	// Stack pointer after reset
	localparam word_t spr_reset_value = 32'h0000_1000;

	// Size of the general register file
	localparam int gr_count = 32;

endpackage
